// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ov7670_ctrl_tb
FILELIST  ?= src.f
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: source/ov7670_cam_out.sv
`timescale 1ns/1ps

module ov7670_cam_out (
  input  logic rst,
  input  logic clk,
  input  logic cam_rst_req,
  output logic ov7670_rst_n,
  output logic ov7670_xclk
);

  import ov7670_pkg::*;

  // Divider count, just wide enough for xclk_div
  typedef logic [$clog2(xclk_div)-1:0] div_cnt_t;

  div_cnt_t div_cnt;

  // --------------------
  // Camera clock
  // --------------------

  // Modulo counter, upper bit gives a 50 % duty cycle
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      div_cnt <= '0;
    end else if (div_cnt == div_cnt_t'(xclk_div - 1)) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Low for the first half, high for the second
  assign ov7670_xclk = div_cnt[$bits(div_cnt)-1];

  // --------------------
  // Camera reset pin
  // --------------------

  // Registered so the pin never glitches, held low in reset
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      ov7670_rst_n <= 1'b0;
    end else begin
      ov7670_rst_n <= ~cam_rst_req;
    end
  end

  a_div_cnt_range: assert property (
    @(posedge rst) disable iff (clk)
    32'(div_cnt) < xclk_div
  ) else $error("xclk divider count out of range");

endmodule

// File: source/ov7670_ctrl.sv
`timescale 1ns/1ps

module ov7670_ctrl #(
  parameter int unsigned wait_cycles = ov7670_pkg::wait_cycles_default
) (
  input  logic                  rst,
  input  logic                  clk,
  input  logic                  test_mode,
  input  logic                  resend,
  input  logic                  sccb_ready,
  output logic                  start_tx,
  output logic                  done,
  output ov7670_pkg::reg_addr_t addr,
  output ov7670_pkg::reg_data_t data_wr,
  output logic                  ov7670_rst_n,
  output logic                  ov7670_xclk
);

  // FSM request to hold the camera in reset
  logic cam_rst_req;

  // --------------------
  // Table sequencing
  // --------------------

  // Advances on each write the FSM offers
  ov7670_reg_seq ov7670_reg_seq_inst (
    .rst       (rst),
    .clk       (clk),
    .test_mode (test_mode),
    .resend    (resend),
    .start_tx  (start_tx),
    .addr      (addr),
    .data_wr   (data_wr),
    .done      (done)
  );

  // Camera reset, waits and the transmitter handshake
  ov7670_init_fsm #(
    .wait_cycles (wait_cycles)
  ) ov7670_init_fsm_inst (
    .rst         (rst),
    .clk         (clk),
    .sccb_ready  (sccb_ready),
    .done        (done),
    .start_tx    (start_tx),
    .cam_rst_req (cam_rst_req)
  );

  // --------------------
  // Camera pins
  // --------------------

  ov7670_cam_out ov7670_cam_out_inst (
    .rst          (rst),
    .clk          (clk),
    .cam_rst_req  (cam_rst_req),
    .ov7670_rst_n (ov7670_rst_n),
    .ov7670_xclk  (ov7670_xclk)
  );

endmodule

// File: source/ov7670_init_fsm.sv
`timescale 1ns/1ps

module ov7670_init_fsm #(
  parameter int unsigned wait_cycles = ov7670_pkg::wait_cycles_default
) (
  input  logic rst,
  input  logic clk,
  input  logic sccb_ready,
  input  logic done,
  output logic start_tx,
  output logic cam_rst_req
);

  import ov7670_pkg::*;

  // State register and next state
  ctrl_state_e             state_q;
  ctrl_state_e             state_d;
  // Shared wait counter
  logic [wait_cnt_w-1:0]   wait_cnt;
  // Counter runs in the three waiting states
  logic                    cnt_en;
  // Last cycle of a wait period
  logic                    wait_end;

  // --------------------
  // Wait counter
  // --------------------

  // Reset hold, settling, and the gap after each write
  assign cnt_en = (state_q == st_rstcam) ||
                  (state_q == st_wait_rstcam) ||
                  (state_q == st_write_reg);

  // Period is wait_cycles+1 cycles, from 0 up to wait_cycles
  assign wait_end = (wait_cnt == wait_cnt_w'(wait_cycles));

  // Wraps on its own at the end so the next wait starts at 0
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      wait_cnt <= '0;
    end else if (!cnt_en) begin
      wait_cnt <= '0;
    end else if (wait_end) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // --------------------
  // State machine
  // --------------------

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q <= st_rstcam;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    // Defaults, stay put with no strobe
    state_d     = state_q;
    start_tx    = 1'b0;
    cam_rst_req = 1'b0;
    unique case (state_q)
      // Camera held in reset for one wait period
      st_rstcam: begin
        cam_rst_req = 1'b1;
        if (wait_end) begin
          state_d = st_wait_rstcam;
        end
      end
      // Camera out of reset, let it settle
      st_wait_rstcam: begin
        if (wait_end) begin
          state_d = st_wait_ready;
        end
      end
      // Table end wins over a pending ready
      st_wait_ready: begin
        if (done) begin
          state_d = st_done;
        end else if (sccb_ready) begin
          start_tx = 1'b1;
          state_d  = st_write_reg;
        end
      end
      // Gap after each write, entry updates inside it
      st_write_reg: begin
        if (wait_end) begin
          state_d = st_wait_ready;
        end
      end
      // done drops on resend or mode change
      // whole sequence begins again from camera reset
      st_done: begin
        if (!done) begin
          state_d = st_rstcam;
        end
      end
      default: begin
        state_d = st_rstcam;
      end
    endcase
  end

  // --------------------
  // Checks
  // --------------------

  // Writes only go out to a ready transmitter
  a_start_needs_ready: assert property (
    @(posedge rst) disable iff (clk)
    start_tx |-> sccb_ready
  ) else $error("start_tx without sccb_ready");

  // A write is always followed by a wait period
  a_start_single_cycle: assert property (
    @(posedge rst) disable iff (clk)
    start_tx |=> !start_tx
  ) else $error("start_tx high in consecutive cycles");

  // Counter must wrap at the programmed length
  a_wait_cnt_range: assert property (
    @(posedge rst) disable iff (clk)
    wait_cnt <= wait_cnt_w'(wait_cycles)
  ) else $error("wait counter past wait_cycles");

endmodule

// File: source/ov7670_pkg.sv
package ov7670_pkg;

  // --------------------
  // Types
  // --------------------

  // Camera register address and data, one SCCB write each
  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  // Table index, fewer than 64 entries
  typedef logic [5:0] seq_idx_t;

  // Controller states
  typedef enum logic [2:0] {
    st_rstcam,
    st_wait_rstcam,
    st_wait_ready,
    st_write_reg,
    st_done
  } ctrl_state_e;

  // --------------------
  // Constants
  // --------------------

  // Real entries 0x00 to 0x17, end marker above
  localparam int unsigned seq_len = 24;
  // No camera register has this upper nibble
  localparam logic [3:0] end_nibble = 4'hF;
  // SCALING_YSC entry, bit 7 picks the colour bar pattern
  localparam seq_idx_t test_idx = 6'h14;
  localparam reg_data_t test_data = 8'hB5;
  // COM7 reset value held while in reset
  localparam logic [15:0] reset_entry = 16'h1280;
  // System clock to camera clock ratio
  localparam int unsigned xclk_div = 4;
  // 300 ms at 100 MHz
  localparam int unsigned wait_cycles_default = 30_000_000;
  localparam int unsigned wait_cnt_w = 25;

  // --------------------
  // Register table
  // --------------------

  // Upper byte address, lower byte data
  function automatic logic [15:0] reg_table(input seq_idx_t idx, input logic test_mode);
    logic [15:0] entry;
    // Two COM7 resets, then YUV output
    case (idx)
      6'h00: entry = 16'h1280;
      6'h01: entry = 16'h1280;
      6'h02: entry = 16'h1200;
      6'h03: entry = 16'h0902;
      6'h04: entry = 16'h40C0;
      6'h05: entry = 16'h8C00;
      6'h06: entry = 16'h1180;
      6'h07: entry = 16'h0F4B;
      6'h08: entry = 16'h1E37;
      6'h09: entry = 16'h3DC0;
      // HREF and windowing
      6'h0A: entry = 16'h1520;
      6'h0B: entry = 16'h1711;
      6'h0C: entry = 16'h1800;
      6'h0D: entry = 16'h1900;
      6'h0E: entry = 16'h1A00;
      6'h0F: entry = 16'h3200;
      6'h10: entry = 16'h3A04;
      // QQVGA/2 scaling
      6'h11: entry = 16'h0C04;
      6'h12: entry = 16'h3E1B;
      6'h13: entry = 16'h703A;
      6'h14: entry = 16'h7135;
      6'h15: entry = 16'h7233;
      6'h16: entry = 16'h73F3;
      6'h17: entry = 16'hA202;
      default: entry = {end_nibble, 12'hFFF};
    endcase
    // Anything past the table reads as the end marker
    if (idx >= seq_idx_t'(seq_len)) begin
      entry = {end_nibble, 12'hFFF};
    end
    // Colour bar test pattern only differs here
    if (test_mode && (idx == test_idx)) begin
      entry[7:0] = test_data;
    end
    return entry;
  endfunction

endpackage

// File: source/ov7670_reg_seq.sv
`timescale 1ns/1ps

module ov7670_reg_seq (
  input  logic                 rst,
  input  logic                 clk,
  input  logic                 test_mode,
  input  logic                 resend,
  input  logic                 start_tx,
  output ov7670_pkg::reg_addr_t addr,
  output ov7670_pkg::reg_data_t data_wr,
  output logic                 done
);

  import ov7670_pkg::*;

  // Previous test_mode level
  logic        test_mode_q;
  // Restart request, resend or a mode change
  logic        restart;
  // Current table position
  seq_idx_t    idx;
  // Registered table entry, address and data
  logic [15:0] entry;

  // --------------------
  // Restart detection
  // --------------------

  // Keep last cycle's mode to see any edge
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      test_mode_q <= 1'b0;
    end else begin
      test_mode_q <= test_mode;
    end
  end

  // Either edge of test_mode restarts, as does resend
  assign restart = resend | (test_mode ^ test_mode_q);

  // --------------------
  // Index counter
  // --------------------

  // Back to the first entry on restart
  // Otherwise one step per write offered to the transmitter
  // The FSM never strobes once done is up, so no end check here
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      idx <= '0;
    end else if (restart) begin
      idx <= '0;
    end else if (start_tx) begin
      idx <= idx + 1'b1;
    end
  end

  // --------------------
  // Table lookup
  // --------------------

  // One cycle behind the index
  // Test mode selects the colour bar entry at one index
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      entry <= reset_entry;
    end else begin
      entry <= reg_table(idx, test_mode);
    end
  end

  // Split the entry into the write fields
  assign addr    = entry[15:8];
  assign data_wr = entry[7:0];

  // End marker sits in the address nibble
  // Comes from the register only, so done is clean
  assign done = (entry[15:12] == end_nibble);

  // --------------------
  // Checks
  // --------------------

  // The FSM must stop offering writes once the table end is seen
  a_no_start_when_done: assert property (
    @(posedge rst) disable iff (clk)
    !(start_tx && done)
  ) else $error("start_tx raised while done is high");

endmodule

// File: src.f
+incdir+tb
source/ov7670_pkg.sv
source/ov7670_reg_seq.sv
source/ov7670_init_fsm.sv
source/ov7670_cam_out.sv
source/ov7670_ctrl.sv
tb/ov7670_ctrl_tb.sv

// File: tb/ov7670_ctrl_tb_ref.svh
`ifndef OV7670_CTRL_TB_REF_SVH
`define OV7670_CTRL_TB_REF_SVH

// Expected writes, address in the upper byte
localparam logic [15:0] ref_table [24] = '{
  16'h1280, 16'h1280, 16'h1200, 16'h0902, 16'h40C0, 16'h8C00,
  16'h1180, 16'h0F4B, 16'h1E37, 16'h3DC0, 16'h1520, 16'h1711,
  16'h1800, 16'h1900, 16'h1A00, 16'h3200, 16'h3A04, 16'h0C04,
  16'h3E1B, 16'h703A, 16'h7135, 16'h7233, 16'h73F3, 16'hA202
};

// Entry for a write index, colour bar data at 0x14 in test mode
function automatic logic [15:0] ref_entry(input int unsigned idx, input logic tm);
  logic [4:0]  sel;
  logic [15:0] entry;
  sel = idx[4:0];
  if (idx >= 24) begin
    return 16'hFFFF;
  end
  entry = ref_table[sel];
  if (tm && idx == 32'h14) begin
    entry = 16'h71B5;
  end
  return entry;
endfunction

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input int unsigned idx);
  if (got !== exp) begin
    errors_value++;
    $display("FAIL addr: write 0x%02h got 0x%02h expected 0x%02h", idx, got, exp);
  end
endtask

task automatic check_data(input reg_data_t got, input reg_data_t exp, input int unsigned idx);
  if (got !== exp) begin
    errors_value++;
    $display("FAIL data_wr: write 0x%02h got 0x%02h expected 0x%02h", idx, got, exp);
  end
endtask

// Single-bit outputs
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    errors_value++;
    $display("FAIL %s: at %0t ns got 0x%h expected 0x%h", name, $time, got, exp);
  end
endtask

`endif

// File: tb/ov7670_ctrl_tb.sv
`timescale 1ns/1ps

module ov7670_ctrl_tb;

  import ov7670_pkg::*;

  // Short waits keep the run brief
  localparam int unsigned wait_cycles = 20;
  localparam int unsigned clk_period = 8;
  localparam int unsigned reset_cycles = 16;
  // Normal, test mode, normal again, then resend
  localparam int unsigned num_seqs = 4;
  // Cycle budget for one complete sequence
  localparam int unsigned done_limit = seq_len * (wait_cycles + 8) * 4;
  localparam int unsigned timeout_ns = num_seqs * seq_len * (wait_cycles + 8) * clk_period * 4;

  // DUT clock is port rst, DUT reset is port clk
  logic      rst;
  logic      clk;
  logic      test_mode;
  logic      resend;
  logic      sccb_ready;
  logic      start_tx;
  logic      done;
  reg_addr_t addr;
  reg_data_t data_wr;
  logic      ov7670_rst_n;
  logic      ov7670_xclk;

  // Error counters, each written by a single process
  int unsigned errors_value;
  int unsigned errors_other;
  int unsigned wait_timeouts;

  // Monitor state
  int unsigned wr_count;
  int unsigned writes_total;
  int unsigned seqs_done;
  int unsigned cycle_cnt;
  int unsigned gap;
  int unsigned restarts;
  int unsigned restarts_seen;
  logic        rst_low_seen;
  logic        done_q;
  logic [15:0] exp_entry;
  logic [31:0] lfsr;

  `include "ov7670_ctrl_tb_ref.svh"

  ov7670_ctrl #(
    .wait_cycles (wait_cycles)
  ) ov7670_ctrl_inst (
    .rst          (rst),
    .clk          (clk),
    .test_mode    (test_mode),
    .resend       (resend),
    .sccb_ready   (sccb_ready),
    .start_tx     (start_tx),
    .done         (done),
    .addr         (addr),
    .data_wr      (data_wr),
    .ov7670_rst_n (ov7670_rst_n),
    .ov7670_xclk  (ov7670_xclk)
  );

  // --------------------
  // Clock and SCCB model
  // --------------------

  initial begin
    rst = 1'b0;
    forever #(clk_period / 2) rst = ~rst;
  end

  // Transmitter ready, one LFSR bit per cycle
  initial begin
    sccb_ready = 1'b0;
    lfsr = 32'h2362_aabe;
    forever begin
      @(posedge rst);
      #1;
      lfsr = lfsr_step(lfsr);
      sccb_ready = lfsr[0];
    end
  end

  // Non-value failures in plain words
  task automatic report_other(input string msg);
    errors_other++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // --------------------
  // Monitor
  // --------------------

  // Samples mid-cycle, well clear of both edges
  initial begin
    errors_value = 0;
    errors_other = 0;
    wr_count = 0;
    writes_total = 0;
    seqs_done = 0;
    cycle_cnt = 0;
    gap = 0;
    restarts_seen = 0;
    rst_low_seen = 1'b0;
    done_q = 1'b0;
    forever begin
      @(negedge rst);
      // New sequence requested by the stimulus
      if (restarts != restarts_seen) begin
        restarts_seen = restarts;
        wr_count = 0;
        rst_low_seen = 1'b0;
      end
      if (clk) begin
        // Everything quiet while in reset
        cycle_cnt = 0;
        check_bit("start_tx", start_tx, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("ov7670_rst_n", ov7670_rst_n, 1'b0);
        check_bit("ov7670_xclk", ov7670_xclk, 1'b0);
        rst_low_seen = 1'b1;
      end else begin
        // Two cycles low, two high, counted from reset release
        check_bit("ov7670_xclk", ov7670_xclk, (cycle_cnt % xclk_div) >= (xclk_div / 2));
        // Camera still held in reset just after release
        if (cycle_cnt < 2) begin
          check_bit("ov7670_rst_n", ov7670_rst_n, 1'b0);
        end
        cycle_cnt++;
        gap++;
        if (!ov7670_rst_n) begin
          rst_low_seen = 1'b1;
        end
        if (start_tx) begin
          if (!sccb_ready) begin
            report_other("start_tx fired while sccb_ready was low");
          end
          if (done) begin
            report_other("start_tx fired while done was high");
          end
          if (!ov7670_rst_n) begin
            report_other("start_tx fired while the camera was still in reset");
          end
          if (wr_count == 0 && !rst_low_seen) begin
            report_other("sequence started without a camera reset pulse");
          end
          if (wr_count != 0 && gap < wait_cycles) begin
            report_other($sformatf("only %0d cycles between two writes", gap));
          end
          if (wr_count >= seq_len) begin
            report_other("extra write after the end of the table");
          end else begin
            exp_entry = ref_entry(wr_count, test_mode);
            check_addr(addr, exp_entry[15:8], wr_count);
            check_data(data_wr, exp_entry[7:0], wr_count);
          end
          gap = 0;
          wr_count++;
          writes_total++;
        end
        // done only after the full table
        if (done && !done_q) begin
          if (wr_count != seq_len) begin
            report_other($sformatf("done rose after %0d writes", wr_count));
          end
          seqs_done++;
        end
        done_q = done;
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  // Wait on the done level, bounded by one sequence length
  task automatic wait_done(input logic level);
    int unsigned n;
    n = 0;
    while (done !== level && n < done_limit) begin
      @(negedge rst);
      n++;
    end
    if (done !== level) begin
      wait_timeouts++;
      $display("ERROR at %0t ns: done did not reach %0b within %0d cycles",
               $time, level, done_limit);
    end
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) @(posedge rst);
  endtask

  initial begin
    clk = 1'b1;
    test_mode = 1'b0;
    resend = 1'b0;
    restarts = 0;
    wait_timeouts = 0;
    repeat (reset_cycles) @(posedge rst);
    #1;
    clk = 1'b0;
    // Normal table after power-up
    wait_done(1'b1);
    idle(50);
    // Colour bar table, any mode change restarts
    @(posedge rst);
    #1;
    test_mode = 1'b1;
    restarts++;
    wait_done(1'b0);
    wait_done(1'b1);
    idle(50);
    // Back to the normal table
    @(posedge rst);
    #1;
    test_mode = 1'b0;
    restarts++;
    wait_done(1'b0);
    wait_done(1'b1);
    idle(30);
    // One-cycle resend pulse
    @(posedge rst);
    #1;
    resend = 1'b1;
    restarts++;
    @(posedge rst);
    #1;
    resend = 1'b0;
    wait_done(1'b0);
    wait_done(1'b1);
    idle(50);
    if (seqs_done != num_seqs) begin
      $display("ERROR: expected %0d completed sequences, saw %0d", num_seqs, seqs_done);
    end
    $display("Summary: %0d writes, %0d sequences, %0d value errors, %0d other errors, %0d timeouts",
             writes_total, seqs_done, errors_value, errors_other, wait_timeouts);
    if (errors_value == 0 && errors_other == 0 && wait_timeouts == 0 &&
        seqs_done == num_seqs) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the sequence count and wait length
  initial begin
    #(timeout_ns);
    $display("ERROR: watchdog expired after %0d ns before all sequences ended", timeout_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule
